//--- hw/shootout_pkg.sv
// ================================================
// shared types and constants of the shootout core
// scores are SCORE_W bits wide, so WIN_SCORE must fit
// link timing is BIT_CYCLES clocks per serial bit
// ================================================
`default_nettype none

package shootout_pkg;

    localparam int SCORE_W = 3;
    localparam logic [SCORE_W-1:0] WIN_SCORE = 3'd5;   // first to five

    localparam int BIT_CYCLES = 8;
    localparam int BIT_CNT_W = $clog2(BIT_CYCLES);
    localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(BIT_CYCLES - 1);

    typedef enum logic [1:0] {IDLE, KEEPER, SHOOTER, OVER} g_state;

    typedef enum logic {SOLO, MULTI} g_mode;

    typedef enum logic [3:0] {      // byte addresses of the register words
        CTRL   = 4'h0,
        KICK   = 4'h4,
        OPP    = 4'h8,
        STATUS = 4'hC
    } reg_addr_e;

    typedef struct packed {
        logic valid;
        logic scored;
        logic role_done;
    } kick_t;

    typedef struct packed {
        logic                 valid;
        g_state               state;      // role in which the kick happened
        g_mode                mode;
        logic                 scored;
        logic                 done;
        logic [SCORE_W-1:0]   opp_score;
    } round_evt_t;

    typedef struct packed {
        logic                 match_end;
        logic                 match_result;   // 1 = player won
        logic [SCORE_W-1:0]   player;
        logic [SCORE_W-1:0]   enemy;
    } score_t;

    typedef struct packed {
        logic                 flag;
        logic                 scored;
        logic [SCORE_W-1:0]   player;
        logic [2:0]           marker;     // always 3'b111
    } link_byte_t;

endpackage

`default_nettype wire

//--- hw/shootout_regs.sv
// ================================================
// AXI4-Lite slave, 4-bit byte address, 32-bit data
// WSTRB and PROT are not present, responses are OKAY
// AW and W are accepted together, one at a time
// start and kick leave as one-cycle pulses
// ================================================
`default_nettype none

module shootout_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [3:0]                          s_awaddr,
    input  logic                                s_awvalid,
    output logic                                s_awready,
    input  logic [31:0]                         s_wdata,
    input  logic                                s_wvalid,
    output logic                                s_wready,
    output logic [1:0]                          s_bresp,
    output logic                                s_bvalid,
    input  logic                                s_bready,
    input  logic [3:0]                          s_araddr,
    input  logic                                s_arvalid,
    output logic                                s_arready,
    output logic [31:0]                         s_rdata,
    output logic [1:0]                          s_rresp,
    output logic                                s_rvalid,
    input  logic                                s_rready,
    output shootout_pkg::kick_t                 kick,
    output logic                                start,
    output shootout_pkg::g_mode                 mode,
    output logic [shootout_pkg::SCORE_W-1:0]    opp_score,
    input  shootout_pkg::score_t                score,
    input  shootout_pkg::g_state                state,
    input  logic                                link_busy
);

    logic        wr_fire;
    logic        rd_fire;
    logic [31:0] rd_word;

    assign wr_fire = s_awready && s_awvalid;     // wready moves with awready
    assign rd_fire = s_arready && s_arvalid;

    assign s_bresp = 2'b00;
    assign s_rresp = 2'b00;

    // write channel and register decode
    always_ff @(posedge clk) begin
        if (rst) begin
            s_awready <= 1'b0;
            s_wready  <= 1'b0;
            s_bvalid  <= 1'b0;
            kick      <= '0;
            start     <= 1'b0;
            mode      <= shootout_pkg::SOLO;
            opp_score <= '0;
        end else begin
            s_awready <= s_awvalid && s_wvalid && !s_bvalid && !s_awready;
            s_wready  <= s_awvalid && s_wvalid && !s_bvalid && !s_awready;
            kick      <= '0;
            start     <= 1'b0;
            if (s_bvalid && s_bready) s_bvalid <= 1'b0;
            if (wr_fire) begin
                s_bvalid <= 1'b1;
                case (shootout_pkg::reg_addr_e'(s_awaddr))
                    shootout_pkg::CTRL: begin
                        start <= s_wdata[0];
                        mode  <= s_wdata[1] ? shootout_pkg::MULTI : shootout_pkg::SOLO;
                    end
                    shootout_pkg::KICK: kick <= '{valid: 1'b1, scored: s_wdata[0], role_done: 1'b1};
                    shootout_pkg::OPP:  opp_score <= s_wdata[2:0];
                    default: ;          // STATUS is read only
                endcase
            end
        end
    end

    always_comb begin
        rd_word = '0;
        case (shootout_pkg::reg_addr_e'(s_araddr))
            shootout_pkg::CTRL: rd_word[1] = (mode == shootout_pkg::MULTI);
            shootout_pkg::OPP:  rd_word[2:0] = opp_score;
            shootout_pkg::STATUS: begin
                rd_word[2:0]   = score.player;
                rd_word[6:4]   = score.enemy;
                rd_word[8]     = score.match_end;
                rd_word[9]     = score.match_result;
                rd_word[11:10] = state;
                rd_word[12]    = link_busy;
            end
            default: rd_word = '0;      // KICK reads back as zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_arready <= 1'b0;
            s_rvalid  <= 1'b0;
        end else begin
            s_arready <= s_arvalid && !s_rvalid && !s_arready;
            if (s_rvalid && s_rready) s_rvalid <= 1'b0;
            if (rd_fire) s_rvalid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) s_rdata <= rd_word;    // sampled at the AR handshake
    end

endmodule

`default_nettype wire

//--- hw/round_sequencer.sv
// ================================================
// match FSM over IDLE, KEEPER, SHOOTER and OVER
// solo play alternates roles after every kick,
// multiplayer stays in KEEPER for the whole match
// start wins over match_end and over a kick
// ================================================
`default_nettype none

module round_sequencer (
    input  logic                                clk,
    input  logic                                rst,
    input  shootout_pkg::kick_t                 kick,
    input  logic                                start,
    input  shootout_pkg::g_mode                 mode,
    input  logic [shootout_pkg::SCORE_W-1:0]    opp_score,
    input  shootout_pkg::score_t                score,
    output shootout_pkg::g_state                state,
    output shootout_pkg::round_evt_t            evt
);

    logic playing;
    shootout_pkg::g_state next_role;

    assign playing = (state == shootout_pkg::KEEPER) || (state == shootout_pkg::SHOOTER);

    always_comb begin
        next_role = state;
        if (mode == shootout_pkg::SOLO) begin
            next_role = (state == shootout_pkg::KEEPER) ? shootout_pkg::SHOOTER
                                                        : shootout_pkg::KEEPER;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= shootout_pkg::IDLE;
            evt   <= '0;
        end else begin
            evt.valid <= 1'b0;      // event is a single-cycle strobe
            if (start) begin
                state <= (mode == shootout_pkg::MULTI) ? shootout_pkg::KEEPER
                                                       : shootout_pkg::SHOOTER;
            end else if (playing) begin
                if (score.match_end) begin
                    state <= shootout_pkg::OVER;
                end else if (kick.valid) begin
                    evt <= '{
                        valid:     1'b1,
                        state:     state,
                        mode:      mode,
                        scored:    kick.scored,
                        done:      kick.role_done,
                        opp_score: opp_score
                    };
                    state <= next_role;
                end
            end
            // kicks seen in IDLE or OVER fall through here unused
        end
    end

endmodule

`default_nettype wire

//--- hw/score_control.sv
// ================================================
// goal counting and match-end decision
// scores only move on a valid event with done set
// events after match_end are ignored until start
// enemy wraps if the opponent reports 7 and scores
// ================================================
`default_nettype none

module score_control (
    input  logic                        clk,
    input  logic                        rst,
    input  shootout_pkg::round_evt_t    evt,
    input  logic                        start,
    output shootout_pkg::score_t        score,
    output shootout_pkg::link_byte_t    link_byte,
    output logic                        send
);

    logic [shootout_pkg::SCORE_W-1:0] player_nxt;
    logic [shootout_pkg::SCORE_W-1:0] enemy_nxt;
    logic                             match_end_nxt;
    logic                             match_result_nxt;
    logic                             take;
    shootout_pkg::link_byte_t         link_byte_nxt;

    assign take = evt.valid && evt.done && !score.match_end;

    always_comb begin
        player_nxt = score.player;
        enemy_nxt  = score.enemy;
        if (take) begin
            case (evt.mode)
                shootout_pkg::SOLO: begin
                    if (evt.state == shootout_pkg::KEEPER && evt.scored) begin
                        enemy_nxt = score.enemy + 3'd1;     // goal conceded
                    end else if (evt.state == shootout_pkg::SHOOTER && evt.scored) begin
                        player_nxt = score.player + 3'd1;
                    end
                end
                shootout_pkg::MULTI: begin
                    if (evt.state == shootout_pkg::KEEPER) begin
                        if (evt.scored) begin
                            enemy_nxt = evt.opp_score + 3'd1;
                        end else begin
                            player_nxt = score.player + 3'd1;   // save counts for us
                            enemy_nxt  = evt.opp_score;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // end decided from the new counts, so it lands with them
    always_comb begin
        match_end_nxt    = score.match_end;
        match_result_nxt = score.match_result;
        if (take) begin
            match_result_nxt = (player_nxt >= shootout_pkg::WIN_SCORE);
            match_end_nxt    = (player_nxt >= shootout_pkg::WIN_SCORE) ||
                               (enemy_nxt >= shootout_pkg::WIN_SCORE);
        end
    end

    always_comb begin
        link_byte_nxt = '{flag: evt.done, scored: evt.scored, player: player_nxt,
                          marker: 3'b111};
    end

    always_ff @(posedge clk) begin
        if (rst || start) begin
            score <= '0;
        end else begin
            score <= '{match_end: match_end_nxt, match_result: match_result_nxt,
                       player: player_nxt, enemy: enemy_nxt};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            send <= 1'b0;
        end else begin
            send <= take;                   // one frame per counted round
        end
    end

    always_ff @(posedge clk) begin : link_load
        if (take) link_byte <= link_byte_nxt;
    end

endmodule

`default_nettype wire

//--- hw/score_link_tx.sv
// ================================================
// 8N1 serializer, LSB first, BIT_CYCLES per bit
// one byte can wait while a frame is on the line,
// a newer send replaces the waiting byte
// line rests high between frames
// ================================================
`default_nettype none

module score_link_tx (
    input  logic                        clk,
    input  logic                        rst,
    input  shootout_pkg::link_byte_t    link_byte,
    input  logic                        send,
    output logic                        busy,
    output logic                        link_tx
);

    logic [shootout_pkg::BIT_CNT_W-1:0] bit_cnt;
    logic [3:0]                         bits_left;
    logic [9:0]                         shift;      // stop, data, start
    logic                               pend_valid;
    shootout_pkg::link_byte_t           pend_byte;

    assign link_tx = busy ? shift[0] : 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            pend_valid <= 1'b0;
            bit_cnt    <= '0;
            bits_left  <= '0;
        end else if (!busy) begin
            bit_cnt   <= '0;
            bits_left <= 4'd9;
            if (send || pend_valid) begin
                busy       <= 1'b1;
                pend_valid <= 1'b0;         // a fresh send supersedes the held byte
                shift      <= {1'b1, send ? link_byte : pend_byte, 1'b0};
            end
        end else begin
            if (send) begin
                pend_valid <= 1'b1;
                pend_byte  <= link_byte;
            end
            if (bit_cnt == shootout_pkg::BIT_LAST) begin
                bit_cnt <= '0;
                if (bits_left == 4'd0) begin
                    busy <= 1'b0;
                end else begin
                    bits_left <= bits_left - 4'd1;
                    shift     <= {1'b1, shift[9:1]};
                end
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/shootout_top.sv
// ================================================
// shootout scoring core, AXI4-Lite host port
// regs -> sequencer -> score control -> link tx
// link_tx is an 8N1 line that idles high
// ================================================
`default_nettype none

module shootout_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  s_awaddr,
    input  logic        s_awvalid,
    output logic        s_awready,
    input  logic [31:0] s_wdata,
    input  logic        s_wvalid,
    output logic        s_wready,
    output logic [1:0]  s_bresp,
    output logic        s_bvalid,
    input  logic        s_bready,
    input  logic [3:0]  s_araddr,
    input  logic        s_arvalid,
    output logic        s_arready,
    output logic [31:0] s_rdata,
    output logic [1:0]  s_rresp,
    output logic        s_rvalid,
    input  logic        s_rready,
    output logic        link_tx
);

    shootout_pkg::kick_t              kick;
    logic                             start;
    shootout_pkg::g_mode              mode;
    logic [shootout_pkg::SCORE_W-1:0] opp_score;
    shootout_pkg::score_t             score;
    shootout_pkg::g_state             state;
    shootout_pkg::round_evt_t         evt;
    shootout_pkg::link_byte_t         link_byte;
    logic                             send;
    logic                             link_busy;

    shootout_regs u_regs (
        .clk, .rst,
        .s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wvalid, .s_wready,
        .s_bresp, .s_bvalid, .s_bready,
        .s_araddr, .s_arvalid, .s_arready, .s_rdata, .s_rresp, .s_rvalid, .s_rready,
        .kick, .start, .mode, .opp_score, .score, .state, .link_busy
    );

    round_sequencer u_seq (
        .clk, .rst, .kick, .start, .mode, .opp_score, .score, .state, .evt
    );

    score_control u_score (
        .clk, .rst, .evt, .start, .score, .link_byte, .send
    );

    score_link_tx u_link (
        .clk, .rst, .link_byte, .send, .busy(link_busy), .link_tx
    );

endmodule

`default_nettype wire

//--- dv/clk_gen.sv
// ==================================================
// free-running testbench clock, period 4
// starts low, first rising edge at time 2
// ==================================================
`default_nettype none

module clk_gen (
    output logic clk
);

    initial clk = 1'b0;

    always #2 clk = ~clk;       // half period

endmodule

`default_nettype wire

//--- dv/tb_shootout.sv
// ==================================================
// testbench for shootout_top, inputs change on falling edges
// stimulus from a 32-bit Fibonacci LFSR with a fixed seed
// STATUS compared with a model of the scoring rules
// link frames decoded mid-bit, expected 80 cycles long
// ==================================================
`default_nettype none

module tb_shootout;

    logic        clk;
    logic        rst;
    logic [3:0]  s_awaddr;
    logic        s_awvalid;
    logic        s_awready;
    logic [31:0] s_wdata;
    logic        s_wvalid;
    logic        s_wready;
    logic [1:0]  s_bresp;
    logic        s_bvalid;
    logic        s_bready;
    logic [3:0]  s_araddr;
    logic        s_arvalid;
    logic        s_arready;
    logic [31:0] s_rdata;
    logic [1:0]  s_rresp;
    logic        s_rvalid;
    logic        s_rready;
    logic        link_tx;

    int          wait_limit = 2000;     // cycles allowed per wait
    longint      cyc = 0;
    int          passes = 0;
    int          fails = 0;
    int          frames = 0;
    bit          frame_active = 1'b0;
    logic [31:0] lfsr = 32'hf1ad6958;
    logic [7:0]  exp_bytes[$];          // link bytes in send order
    longint      exp_avail[$];          // edge at which each byte reaches the serializer

    shootout_pkg::g_state m_state;
    shootout_pkg::g_mode  m_mode;
    logic [2:0]  m_player;
    logic [2:0]  m_enemy;
    logic [2:0]  m_opp;
    logic        m_end;
    logic        m_result;

    clk_gen u_clk (.clk);

    shootout_top uut (
        .clk, .rst,
        .s_awaddr, .s_awvalid, .s_awready, .s_wdata, .s_wvalid, .s_wready,
        .s_bresp, .s_bvalid, .s_bready,
        .s_araddr, .s_arvalid, .s_arready, .s_rdata, .s_rresp, .s_rvalid, .s_rready,
        .link_tx
    );

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("error %s: got %h, expected %h", name, got, want);
            fails++;
        end else begin
            passes++;
        end
    endtask

    task automatic note_timeout(input string what);
        $display("timeout: %s", what);
        fails++;
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input int stall, output longint hs_cyc);
        int t;
        @(negedge clk);
        s_awaddr  = addr;
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        t = 0;
        while (!s_awready && t < wait_limit) begin
            @(negedge clk);
            t++;
        end
        if (!s_awready) begin
            note_timeout("write was never accepted");
        end else begin
            compare_field("s_wready", 32'(s_wready), 32'd1);
        end
        hs_cyc = cyc + 1;                   // handshake on the coming edge
        @(negedge clk);
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        t = 0;
        while (!s_bvalid && t < wait_limit) begin
            @(negedge clk);
            t++;
        end
        if (!s_bvalid) begin
            note_timeout("write response never arrived");
        end else begin
            compare_field("s_bresp", 32'(s_bresp), 32'd0);
        end
        repeat (stall) @(negedge clk);      // hold off BREADY
        if (!s_bvalid) begin
            $display("write response was dropped before BREADY");
            fails++;
        end
        s_bready = 1'b1;
        @(negedge clk);
        s_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [3:0] addr, input int stall,
                            output logic [31:0] data);
        int t;
        @(negedge clk);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        t = 0;
        while (!s_arready && t < wait_limit) begin
            @(negedge clk);
            t++;
        end
        if (!s_arready) note_timeout("read was never accepted");
        @(negedge clk);
        s_arvalid = 1'b0;
        t = 0;
        while (!s_rvalid && t < wait_limit) begin
            @(negedge clk);
            t++;
        end
        if (!s_rvalid) begin
            note_timeout("read data never arrived");
        end else begin
            compare_field("s_rresp", 32'(s_rresp), 32'd0);
        end
        repeat (stall) @(negedge clk);      // hold off RREADY
        if (!s_rvalid) begin
            $display("read data was dropped before RREADY");
            fails++;
        end
        data = s_rdata;
        s_rready = 1'b1;
        @(negedge clk);
        s_rready = 1'b0;
    endtask

    task automatic check_status(input int stall);
        logic [31:0] d;
        axi_read(shootout_pkg::STATUS, stall, d);
        compare_field("status.player", 32'(d[2:0]), 32'(m_player));
        compare_field("status.enemy", 32'(d[6:4]), 32'(m_enemy));
        compare_field("status.match_end", 32'(d[8]), 32'(m_end));
        compare_field("status.match_result", 32'(d[9]), 32'(m_result));
        compare_field("status.state", 32'(d[11:10]), 32'(m_state));
    endtask

    task automatic check_link_busy(input logic want);
        logic [31:0] d;
        axi_read(shootout_pkg::STATUS, 0, d);
        compare_field("status.link_busy", 32'(d[12]), 32'(want));
    endtask

    task automatic start_match(input shootout_pkg::g_mode md);
        longint hs;
        axi_write(shootout_pkg::CTRL, {30'b0, md == shootout_pkg::MULTI, 1'b1}, 0, hs);
        m_mode   = md;
        m_player = '0;
        m_enemy  = '0;
        m_end    = 1'b0;
        m_result = 1'b0;
        m_state  = (md == shootout_pkg::MULTI) ? shootout_pkg::KEEPER : shootout_pkg::SHOOTER;
    endtask

    task automatic do_kick(input logic scored);
        logic   counted;
        longint hs;
        counted = (m_state == shootout_pkg::KEEPER) || (m_state == shootout_pkg::SHOOTER);
        axi_write(shootout_pkg::KICK, {31'b0, scored}, 0, hs);
        if (counted) begin
            if (m_mode == shootout_pkg::MULTI) begin
                if (scored) begin
                    m_enemy = m_opp + 3'd1;
                end else begin
                    m_player = m_player + 3'd1;     // a save is ours
                    m_enemy  = m_opp;
                end
            end else if (scored && m_state == shootout_pkg::KEEPER) begin
                m_enemy = m_enemy + 3'd1;
            end else if (scored) begin
                m_player = m_player + 3'd1;
            end
            m_result = (m_player >= 3'd5);
            m_end    = m_result || (m_enemy >= 3'd5);
            if (m_end) begin
                m_state = shootout_pkg::OVER;
            end else if (m_mode == shootout_pkg::SOLO) begin
                m_state = (m_state == shootout_pkg::KEEPER) ? shootout_pkg::SHOOTER
                                                            : shootout_pkg::KEEPER;
            end
            exp_bytes.push_back({1'b1, scored, m_player, 3'b111});
            exp_avail.push_back(hs + 3);    // kick, event, send, then serializer
        end
    endtask

    task automatic end_test(input int num, input string name, input int mark);
        $display("test %0d %s: %0d errors", num, name, fails - mark);
    endtask

    // 8N1 sampler, mid-bit on falling edges
    initial begin : link_monitor
        logic [7:0] got;
        logic [7:0] want;
        longint     p0;
        bit         found;
        forever begin
            @(negedge clk);
            if (!rst && link_tx === 1'b0) begin
                frame_active = 1'b1;
                p0 = cyc;                   // edge that loaded the frame
                repeat (4) @(negedge clk);
                if (link_tx !== 1'b0) begin
                    $display("link start bit ended early at frame %0d", frames + 1);
                    fails++;
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (8) @(negedge clk);
                    got[i] = link_tx;
                end
                repeat (8) @(negedge clk);
                frames++;
                if (link_tx !== 1'b1) begin
                    $display("link frame %0d has no valid stop bit", frames);
                    fails++;
                end
                found = 1'b0;
                while (exp_avail.size() > 0 && exp_avail[0] <= p0) begin
                    want = exp_bytes.pop_front();   // older bytes were overwritten
                    void'(exp_avail.pop_front());
                    found = 1'b1;
                end
                if (!found) begin
                    $display("link frame %0d was sent with no byte expected", frames);
                    fails++;
                end else if (got !== want) begin
                    $display("error link_byte: got %h, expected %h", got, want);
                    fails++;
                end else begin
                    passes++;
                end
                frame_active = 1'b0;
            end
        end
    end

    initial begin
        logic [31:0] d;
        logic [2:0]  v;
        int          mark;
        int          t;
        longint      hs;
        rst       = 1'b1;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        m_state   = shootout_pkg::IDLE;
        m_mode    = shootout_pkg::SOLO;
        m_player  = '0;
        m_enemy   = '0;
        m_opp     = '0;
        m_end     = 1'b0;
        m_result  = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        mark = fails;
        check_status(0);
        check_link_busy(1'b0);
        compare_field("link_tx", 32'(link_tx), 32'd1);
        do_kick(1'b1);                      // no match yet, dropped
        check_status(0);
        end_test(1, "reset state", mark);

        mark = fails;
        start_match(shootout_pkg::SOLO);
        for (int k = 0; k < 40 && !m_end; k++) begin
            do_kick(rand_bits(1) != 0);
            check_status(0);
            if (k == 0) check_link_busy(1'b1);  // first frame is still on the line
        end
        if (!m_end) begin
            $display("solo match did not end within 40 kicks");
            fails++;
        end
        end_test(2, "solo match", mark);

        mark = fails;
        start_match(shootout_pkg::MULTI);
        for (int k = 0; k < 40 && !m_end; k++) begin
            v = 3'(rand_bits(2));
            m_opp = v + 3'(rand_bits(1));   // opponent score 0 to 4
            axi_write(shootout_pkg::OPP, {29'b0, m_opp}, 0, hs);
            do_kick(rand_bits(1) != 0);
            check_status(0);
        end
        if (!m_end) begin
            $display("multiplayer match did not end within 40 kicks");
            fails++;
        end
        end_test(3, "multiplayer match", mark);

        mark = fails;
        check_status(0);
        for (int k = 0; k < 3; k++) begin
            do_kick(rand_bits(1) != 0);
            check_status(0);
        end
        start_match(shootout_pkg::SOLO);
        check_status(0);
        end_test(4, "kicks after match end and restart", mark);

        mark = fails;
        t = 0;
        while ((exp_bytes.size() != 0 || frame_active) && t < wait_limit) begin
            @(negedge clk);
            t++;
        end
        if (exp_bytes.size() != 0 || frame_active) note_timeout("link bytes still pending");
        if (frames == 0) begin
            $display("no link frames were decoded");
            fails++;
        end
        end_test(5, "link frames", mark);

        mark = fails;
        for (int k = 0; k < 6; k++) begin
            v = 3'(rand_bits(3));
            axi_write(shootout_pkg::OPP, {29'b0, v}, int'(rand_bits(4)), hs);
            m_opp = v;
            axi_read(shootout_pkg::OPP, int'(rand_bits(4)), d);
            compare_field("opp_score", d, {29'b0, v});
            check_status(int'(rand_bits(4)));
        end
        check_link_busy(1'b0);              // no kicks since the link drained
        end_test(6, "response back-pressure", mark);

        $display("checks passed %0d, failed %0d", passes, fails);
        if (fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hw/shootout_pkg.sv
hw/shootout_regs.sv
hw/round_sequencer.sv
hw/score_control.sv
hw/score_link_tx.sv
hw/shootout_top.sv
dv/clk_gen.sv
dv/tb_shootout.sv

//--- Makefile
# Verilator build and run of the shootout testbench

VERILATOR ?= verilator
TOP       ?= tb_shootout
RTL_TOP   ?= shootout_top
SEED      ?= 0
LOG       ?= sim.log
OBJ       ?= obj_dir
VFLAGS    ?= --binary --timing
FLIST     ?= vlog.f

SRCS := $(shell cat $(FLIST))

.PHONY: run lint clean

run: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || echo "sim failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi

$(OBJ)/V$(TOP): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ)

lint:
	$(VERILATOR) --lint-only -Wall -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ) $(LOG)
